// ==== Bender.yml ====
package:
  name: vscaler

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/video_pkg.sv
      - rtl/vscale_pkg.sv
      - rtl/stream_decode.sv
      - rtl/line_buffer.sv
      - rtl/line_repeat.sv
      - rtl/stream_result.sv
      - rtl/vscaler.sv
  - target: simulation
    files:
      - verif/clk_gen.sv
      - verif/vscaler_tb.sv

// ==== all.f ====
+incdir+rtl
rtl/video_pkg.sv
rtl/vscale_pkg.sv
rtl/stream_decode.sv
rtl/line_buffer.sv
rtl/line_repeat.sv
rtl/stream_result.sv
rtl/vscaler.sv
verif/clk_gen.sv
verif/vscaler_tb.sv

// ==== rtl/line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vscale_defines.svh"

module line_buffer
	import video_pkg::*, vscale_pkg::*;
(
	input  logic   clk,
	input  logic   wr_en,
	input  bank_t  wr_bank,
	input  col_t   wr_addr,
	input  pixel_t wr_data,
	input  logic   rd_en,
	input  bank_t  rd_bank,
	input  col_t   rd_addr,
	output pixel_t rd_data
);

	// bank index is the top address bit.
	pixel_t mem [0:2*`VSCALE_LINE_DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[{wr_bank, wr_addr}] <= wr_data;
		end
	end

	// registered read for block RAM inference.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[{rd_bank, rd_addr}];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/line_repeat.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_repeat
	import video_pkg::*, vscale_pkg::*;
(
	input  logic       clk,
	input  logic       resetn_tb,
	input  reso_t      s_height,
	input  reso_t      m_height,
	input  logic [1:0] bank_full,
	input  len_t [1:0] bank_len,
	input  logic [1:0] bank_sof,
	output logic       bank_release,
	output bank_t      release_bank,
	output logic       rd_en,
	output bank_t      rd_bank,
	output col_t       rd_addr,
	output logic       item_valid,
	output logic       item_sof,
	output logic       item_eol,
	input  logic       item_ready
);

	rep_state_t state;
	bank_t      rd_ptr;
	col_t       col;
	acc_t       out_acc;
	acc_t       src_end;
	acc_t       out_next;
	logic       line_done;
	logic       fire;

	assign fire = item_valid && item_ready;
	assign out_next = out_acc + acc_t'(s_height);
	assign line_done = ({1'b0, col} + len_t'(1)) == bank_len[rd_ptr];

	assign item_valid = (state == emit);
	// out_acc is zero only on output line 0.
	assign item_sof = (out_acc == '0) && (col == '0);
	assign item_eol = line_done;

	assign rd_en = fire;
	assign rd_bank = rd_ptr;
	assign rd_addr = col;

	assign bank_release = (state == advance);
	assign release_bank = rd_ptr;

	// output line j reads source line i while j*s_height < (i+1)*m_height.
	always_ff @(posedge clk) begin
		if (!resetn_tb) begin
			state <= idle;
			rd_ptr <= '0;
			col <= '0;
			out_acc <= '0;
			src_end <= '0;
		end else begin
			case (state)
				idle: begin
					if (s_height != '0 && m_height != '0) begin
						state <= wait_line;
					end
				end
				wait_line: begin
					if (bank_full[rd_ptr]) begin
						col <= '0;
						if (bank_sof[rd_ptr]) begin
							out_acc <= '0;
							src_end <= acc_t'(m_height);
							state <= emit;
						end else if (out_acc < src_end) begin
							state <= emit;
						end else begin
							state <= advance;
						end
					end
				end
				emit: begin
					if (fire) begin
						if (line_done) begin
							col <= '0;
							out_acc <= out_next;
							// repeat the line while the next output still maps here.
							state <= (out_next < src_end) ? emit : advance;
						end else begin
							col <= col + col_t'(1);
						end
					end
				end
				advance: begin
					src_end <= src_end + acc_t'(m_height);
					rd_ptr <= ~rd_ptr;
					state <= wait_line;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stream_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_decode
	import video_pkg::*, vscale_pkg::*;
(
	input  logic       clk,
	input  logic       resetn_tb,
	input  pixel_t     s_axis_tdata,
	input  logic       s_axis_tuser,
	input  logic       s_axis_tlast,
	input  logic       s_axis_tvalid,
	output logic       s_axis_tready,
	output logic       wr_en,
	output bank_t      wr_bank,
	output col_t       wr_addr,
	output pixel_t     wr_data,
	output logic [1:0] bank_full,
	output len_t [1:0] bank_len,
	output logic [1:0] bank_sof,
	input  logic       bank_release,
	input  bank_t      release_bank
);

	bank_t wr_ptr;
	col_t  col;
	logic  cur_sof;
	logic  line_sof;
	logic  accept;

	// stall while the bank we would write still waits to be read.
	assign s_axis_tready = !bank_full[wr_ptr];
	assign accept = s_axis_tvalid && s_axis_tready;

	assign wr_en = accept;
	assign wr_bank = wr_ptr;
	assign wr_addr = col;
	assign wr_data = s_axis_tdata;

	// tuser only counts on the first pixel of a line.
	assign line_sof = (col == '0) ? s_axis_tuser : cur_sof;

	always_ff @(posedge clk) begin
		if (!resetn_tb) begin
			wr_ptr <= '0;
			col <= '0;
			bank_full <= '0;
		end else begin
			if (bank_release) begin
				bank_full[release_bank] <= 1'b0;
			end
			if (accept) begin
				if (s_axis_tlast) begin
					bank_full[wr_ptr] <= 1'b1;
					wr_ptr <= ~wr_ptr;
					col <= '0;
				end else begin
					col <= col + col_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_sof <= line_sof;
			if (s_axis_tlast) begin
				bank_len[wr_ptr] <= {1'b0, col} + len_t'(1);
				bank_sof[wr_ptr] <= line_sof;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stream_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_result
	import video_pkg::*;
(
	input  logic   clk,
	input  logic   resetn_tb,
	input  pixel_t rd_data,
	input  logic   item_valid,
	input  logic   item_sof,
	input  logic   item_eol,
	output logic   item_ready,
	output pixel_t m_axis_tdata,
	output logic   m_axis_tuser,
	output logic   m_axis_tlast,
	output logic   m_axis_tvalid,
	input  logic   m_axis_tready
);

	pixel_t     q_data [2];
	logic [1:0] q_sof;
	logic [1:0] q_eol;
	logic       q_wr;
	logic       q_rd;
	logic [1:0] count;
	logic       rd_vld_q;
	logic       sof_q;
	logic       eol_q;
	logic       bypass;
	logic       push;
	logic       pop;

	// an item in flight already owns a queue slot.
	assign item_ready = (count + 2'(rd_vld_q)) < 2'd2;

	// empty queue shows the arriving pixel directly.
	assign bypass = (count == 2'd0);
	assign m_axis_tvalid = !bypass || rd_vld_q;
	assign m_axis_tdata = bypass ? rd_data : q_data[q_rd];
	assign m_axis_tuser = bypass ? sof_q : q_sof[q_rd];
	assign m_axis_tlast = bypass ? eol_q : q_eol[q_rd];

	assign pop = !bypass && m_axis_tready;
	assign push = rd_vld_q && !(bypass && m_axis_tready);

	always_ff @(posedge clk) begin
		if (!resetn_tb) begin
			rd_vld_q <= 1'b0;
			count <= '0;
			q_wr <= 1'b0;
			q_rd <= 1'b0;
		end else begin
			rd_vld_q <= item_valid && item_ready;
			count <= count + 2'(push) - 2'(pop);
			if (push) begin
				q_wr <= ~q_wr;
			end
			if (pop) begin
				q_rd <= ~q_rd;
			end
		end
	end

	always_ff @(posedge clk) begin
		// flags follow the RAM read latency.
		sof_q <= item_sof;
		eol_q <= item_eol;
		if (push) begin
			q_data[q_wr] <= rd_data;
			q_sof[q_wr] <= sof_q;
			q_eol[q_wr] <= eol_q;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
`default_nettype none

`include "vscale_defines.svh"

package video_pkg;

	typedef logic [`VSCALE_PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [`VSCALE_RESO_WIDTH-1:0] reso_t;
	typedef logic [`VSCALE_ADDR_WIDTH-1:0] col_t;

	// one bit wider than col_t so a full bank length fits.
	typedef logic [`VSCALE_ADDR_WIDTH:0] len_t;

endpackage

`default_nettype wire

// ==== rtl/vscale_defines.svh ====
`ifndef VSCALE_DEFINES_SVH
`define VSCALE_DEFINES_SVH

// bits per grey pixel.
`define VSCALE_PIXEL_WIDTH 8

// bits of a height or line count.
`define VSCALE_RESO_WIDTH 12

// one bank holds the longest line.
`define VSCALE_LINE_DEPTH 1024
`define VSCALE_ADDR_WIDTH 10

`endif

// ==== rtl/vscale_pkg.sv ====
`default_nettype none

`include "vscale_defines.svh"

package vscale_pkg;

	// holds line index times height.
	typedef logic [2*`VSCALE_RESO_WIDTH-1:0] acc_t;

	typedef logic bank_t;

	typedef enum logic [1:0] {
		idle,
		wait_line,
		emit,
		advance
	} rep_state_t;

endpackage

`default_nettype wire

// ==== rtl/vscaler.sv ====
`timescale 1ns/100ps
`default_nettype none

module vscaler
	import video_pkg::*, vscale_pkg::*;
(
	input  logic   clk,
	input  logic   resetn_tb,
	input  reso_t  s_height,
	input  reso_t  m_height,
	input  pixel_t s_axis_tdata,
	input  logic   s_axis_tuser,
	input  logic   s_axis_tlast,
	input  logic   s_axis_tvalid,
	output logic   s_axis_tready,
	output pixel_t m_axis_tdata,
	output logic   m_axis_tuser,
	output logic   m_axis_tlast,
	output logic   m_axis_tvalid,
	input  logic   m_axis_tready
);

	logic       wr_en;
	bank_t      wr_bank;
	col_t       wr_addr;
	pixel_t     wr_data;
	logic [1:0] bank_full;
	len_t [1:0] bank_len;
	logic [1:0] bank_sof;
	logic       bank_release;
	bank_t      release_bank;
	logic       rd_en;
	bank_t      rd_bank;
	col_t       rd_addr;
	pixel_t     rd_data;
	logic       item_valid;
	logic       item_sof;
	logic       item_eol;
	logic       item_ready;

	stream_decode u_decode (
		.clk           (clk),
		.resetn_tb     (resetn_tb),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.wr_en         (wr_en),
		.wr_bank       (wr_bank),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.bank_full     (bank_full),
		.bank_len      (bank_len),
		.bank_sof      (bank_sof),
		.bank_release  (bank_release),
		.release_bank  (release_bank)
	);

	line_buffer u_lines (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	line_repeat u_repeat (
		.clk          (clk),
		.resetn_tb    (resetn_tb),
		.s_height     (s_height),
		.m_height     (m_height),
		.bank_full    (bank_full),
		.bank_len     (bank_len),
		.bank_sof     (bank_sof),
		.bank_release (bank_release),
		.release_bank (release_bank),
		.rd_en        (rd_en),
		.rd_bank      (rd_bank),
		.rd_addr      (rd_addr),
		.item_valid   (item_valid),
		.item_sof     (item_sof),
		.item_eol     (item_eol),
		.item_ready   (item_ready)
	);

	stream_result u_result (
		.clk           (clk),
		.resetn_tb     (resetn_tb),
		.rd_data       (rd_data),
		.item_valid    (item_valid),
		.item_sof      (item_sof),
		.item_eol      (item_eol),
		.item_ready    (item_ready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
	parameter int HALF_PERIOD = 50
) (
	output logic clk
);

	// 100 ns period by default.
	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== verif/vscaler_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vscaler_tb
	import video_pkg::*;
();

	logic   clk;
	logic   resetn_tb;
	reso_t  s_height;
	reso_t  m_height;
	pixel_t s_axis_tdata;
	logic   s_axis_tuser;
	logic   s_axis_tlast;
	logic   s_axis_tvalid;
	logic   s_axis_tready;
	pixel_t m_axis_tdata;
	logic   m_axis_tuser;
	logic   m_axis_tlast;
	logic   m_axis_tvalid;
	logic   m_axis_tready;

	integer seed;
	int     width;
	int     ready_pct;
	int     out_cnt;
	pixel_t src [0:15][0:7];

	clk_gen u_clk (
		.clk (clk)
	);

	vscaler dut (
		.clk           (clk),
		.resetn_tb     (resetn_tb),
		.s_height      (s_height),
		.m_height      (m_height),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	// output line j shows the nearest source line j*s/m.
	function automatic pixel_t exp_pixel(input int j, input int x);
		return src[(j * int'(s_height)) / int'(m_height)][x];
	endfunction

	task automatic check_value(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Error at %0t: %s mismatch, got %0h, expected %0h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s at time %0t", msg, $time);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin : compare_beats
		int j;
		int x;
		if (resetn_tb && m_axis_tvalid && m_axis_tready) begin
			if (out_cnt >= int'(m_height) * width) begin
				report_failure("an output beat arrived after the frame was complete");
			end
			j = out_cnt / width;
			x = out_cnt % width;
			check_value(m_axis_tdata, exp_pixel(j, x), "tdata");
			check_value(m_axis_tuser, (j == 0 && x == 0), "tuser");
			check_value(m_axis_tlast, (x == width - 1), "tlast");
			out_cnt++;
		end
	end

	// random output back-pressure.
	always @(posedge clk) begin
		#5;
		m_axis_tready = ($unsigned($random(seed)) % 100) < ready_pct;
	end

	task automatic send_frame(input int lines);
		int wait_cnt;
		int gap;
		for (int l = 0; l < lines; l++) begin
			for (int x = 0; x < width; x++) begin
				gap = $unsigned($random(seed)) % 3;
				repeat (gap) begin
					@(posedge clk);
					#10;
				end
				s_axis_tvalid = 1'b1;
				s_axis_tdata = src[l][x];
				s_axis_tuser = (l == 0 && x == 0);
				s_axis_tlast = (x == width - 1);
				wait_cnt = 0;
				do begin
					@(posedge clk);
					wait_cnt++;
					if (wait_cnt > 2000) begin
						report_failure("an input beat was never accepted");
					end
				end while (!s_axis_tready);
				#10;
				s_axis_tvalid = 1'b0;
			end
		end
	endtask

	task automatic wait_output();
		int idle_cnt;
		int last_cnt;
		idle_cnt = 0;
		last_cnt = out_cnt;
		while (out_cnt < int'(m_height) * width) begin
			@(posedge clk);
			#10;
			if (out_cnt != last_cnt) begin
				idle_cnt = 0;
				last_cnt = out_cnt;
			end else begin
				idle_cnt++;
			end
			if (idle_cnt > 2000) begin
				report_failure("no output beat arrived");
			end
		end
	endtask

	task automatic run_frame(input int s_h, input int m_h, input int w, input int pct);
		s_height = reso_t'(s_h);
		m_height = reso_t'(m_h);
		width = w;
		ready_pct = pct;
		out_cnt = 0;
		for (int l = 0; l < s_h; l++) begin
			for (int x = 0; x < w; x++) begin
				src[l][x] = pixel_t'($random(seed));
			end
		end
		fork
			send_frame(s_h);
			wait_output();
		join
		// skipped source lines drain here and no extra beat may follow.
		repeat (12) begin
			@(posedge clk);
			check_value(m_axis_tvalid, 0, "m_axis_tvalid after frame end");
		end
		#10;
	endtask

	initial begin
		seed = 32'ha1e4;
		out_cnt = 0;
		width = 8;
		ready_pct = 100;
		resetn_tb = 1'b0;
		s_height = 12'd6;
		m_height = 12'd13;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		repeat (5) @(posedge clk);
		#10;
		resetn_tb = 1'b1;
		repeat (10) begin
			@(posedge clk);
			check_value(m_axis_tvalid, 0, "m_axis_tvalid after reset");
			check_value(s_axis_tready, 1, "s_axis_tready after reset");
		end
		#10;
		run_frame(6, 13, 8, 70);
		run_frame(12, 5, 8, 70);
		run_frame(7, 7, 8, 20);
		// two frames in a row with heights changed only between them.
		run_frame(5, 9, 8, 60);
		run_frame(9, 4, 8, 90);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
